/* Makefile */
# Verilator build and run for the LPIF link testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module lpif_link_tb \
	  -f compile.f -Mdir obj_dir -o lpif_link_sim

# Pass only when the pass message shows up in the output
run: compile
	@out="$$(./obj_dir/lpif_link_sim)"; echo "$$out"; \
	  echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir

/* compile.f */
src/lpif_pkg.sv
src/link_online_sync.sv
src/flit_lane_splitter.sv
src/phy_lane.sv
src/flit_lane_merger.sv
src/lpif_link_top.sv
dv/tb_clock_gen.sv
dv/lpif_link_checker.sv
dv/lpif_link_tb.sv

/* dv/lpif_link_checker.sv */
/*
 * Online gating assertions for the LPIF link
 * Lanes stay silent and upstream valid stays low while offline
 */

`timescale 1ns/100ps

module lpif_link_checker import lpif_pkg::*; (
  input logic                 clk_wr,
  input logic                 rst_n,
  input logic                 tx_online_delay,
  input logic                 rx_online_delay,
  input logic [PHY_WIDTH-1:0] tx_phy0,
  input logic [PHY_WIDTH-1:0] tx_phy1,
  input logic                 ustrm_valid
);

  // Read by the testbench at the end of the run
  int unsigned assert_fail_count = 0;

  ////////////////////////////////////////
  // Transmit gating
  ////////////////////////////////////////

  // Lane register adds one cycle after the delayed online
  tx_quiet: assert property (@(posedge clk_wr) disable iff (!rst_n)
    !tx_online_delay |=> (tx_phy0 == '0) && (tx_phy1 == '0))
    else begin
      $error("lane word not zero while transmit side offline");
      assert_fail_count++;
    end

  // Framing bits on every online word
  tx_framed: assert property (@(posedge clk_wr) disable iff (!rst_n)
    tx_online_delay |=> (tx_phy0[PHY_WIDTH-1 -: 2] == 2'b11))
    else begin
      $error("lane 0 word missing strobe or marker while online");
      assert_fail_count++;
    end

  ////////////////////////////////////////
  // Receive gating
  ////////////////////////////////////////

  // rx_ok then merger register, two cycles
  rx_quiet: assert property (@(posedge clk_wr) disable iff (!rst_n)
    !rx_online_delay |-> ##2 !ustrm_valid)
    else begin
      $error("upstream valid high while receive side offline");
      assert_fail_count++;
    end

endmodule

bind lpif_link_top lpif_link_checker u_checker (.*);

/* dv/lpif_link_tb.sv */
/*
 * LPIF link layer testbench
 * Loops both PHY lanes back, drives random flits and checks the
 * upstream flit, lane words, online delays and status counters
 */

`timescale 1ns/100ps

module lpif_link_tb import lpif_pkg::*; ();

  logic                   clk_wr;
  logic                   rst_n;
  logic                   tx_online, rx_online;
  logic [DELAY_WIDTH-1:0] delay_x_value, delay_xz_value, delay_yz_value;
  logic [3:0]             dstrm_state, ustrm_state;
  logic [1:0]             dstrm_protid, ustrm_protid;
  logic [31:0]            dstrm_data, ustrm_data;
  logic                   dstrm_dvalid, ustrm_dvalid;
  logic [15:0]            dstrm_crc, ustrm_crc;
  logic                   dstrm_crc_valid, ustrm_crc_valid;
  logic                   dstrm_valid, ustrm_valid;
  logic [PHY_WIDTH-1:0]   tx_phy0, tx_phy1, rx_phy0, rx_phy1;
  logic [31:0]            tx_downstream_debug_status, rx_upstream_debug_status;

  // Test hooks
  logic check_en;
  logic force_marker;

  // One entry per clock, indexed by negedge count
  logic [FLIT_WIDTH-1:0] flit_hist [$];
  bit                    check_hist [$];
  bit                    force_hist [$];

  int unsigned valid_count;
  int          value_errors;
  int          other_errors;
  int          edges;
  int          force_cycles;
  logic [31:0] align_base;
  bit          timed_out;

  tb_clock_gen u_clock_gen (.clk_wr(clk_wr), .rst_n(rst_n));

  // Loopback, lane 1 marker can be knocked out
  assign rx_phy0 = tx_phy0;
  assign rx_phy1 = force_marker ?
                   {tx_phy1[PHY_WIDTH-1], 1'b0, tx_phy1[PHY_WIDTH-3:0]} : tx_phy1;

  lpif_link_top dut (.*);

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  function automatic logic [FLIT_WIDTH-1:0] pack_dstrm();
    return {dstrm_state, dstrm_protid, dstrm_data, dstrm_dvalid,
            dstrm_crc, dstrm_crc_valid, dstrm_valid};
  endfunction

  function automatic logic [FLIT_WIDTH-1:0] pack_ustrm();
    return {ustrm_state, ustrm_protid, ustrm_data, ustrm_dvalid,
            ustrm_crc, ustrm_crc_valid, ustrm_valid};
  endfunction

  // Lane 0 gets bits 37..0, lane 1 gets 56..38 zero extended
  function automatic lane_payload_t lane_slice(input logic [FLIT_WIDTH-1:0] flit, input int lane);
    lane_payload_t slice;
    slice = '0;
    if (lane == 0) begin
      slice = flit[LANE_PAYLOAD_WIDTH-1:0];
    end else begin
      slice[FLIT_WIDTH-LANE_PAYLOAD_WIDTH-1:0] = flit[FLIT_WIDTH-1:LANE_PAYLOAD_WIDTH];
    end
    return slice;
  endfunction

  // Merge back, zero flit unless every lane was good
  function automatic logic [FLIT_WIDTH-1:0] ref_upstream(input logic [FLIT_WIDTH-1:0] flit,
                                                         input logic [1:0] lane_ok);
    lane_payload_t lane0;
    lane_payload_t lane1;
    lane0 = lane_slice(flit, 0);
    lane1 = lane_slice(flit, 1);
    if (!(&lane_ok)) begin
      return '0;
    end
    return {lane1[FLIT_WIDTH-LANE_PAYLOAD_WIDTH-1:0], lane0};
  endfunction

  ////////////////////////////////////////
  // Checking and run control
  ////////////////////////////////////////

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] expected);
    assert (got === expected) else begin
      $display("FAIL %s: expected %h, got %h at %0t", name, expected, got, $time);
      value_errors++;
    end
  endtask

  task automatic finish_run();
    int unsigned checker_fails;
    checker_fails = dut.u_checker.assert_fail_count;
    $display("Error counts: value %0d, other %0d, assertion %0d",
             value_errors, other_errors, checker_fails);
    if (value_errors == 0 && other_errors == 0 && checker_fails == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  endtask

  task automatic report_timeout(input string what);
    $display("Timed out waiting for %s", what);
    other_errors++;
    timed_out = 1'b1;
  endtask

  task automatic wait_reset_release();
    int n;
    n = 0;
    while (!rst_n && n < 100) begin
      @(posedge clk_wr);
      n++;
    end
    if (!rst_n) report_timeout("reset release");
  endtask

  // Edges after the one that first samples the online input
  task automatic count_edges_until(input bit rx_side, output int count);
    bit seen;
    count = 0;
    seen = 1'b0;
    @(posedge clk_wr);
    while (!seen && count < 600) begin
      @(posedge clk_wr);
      #1;
      count++;
      seen = rx_side ? dut.rx_online_delay : tx_phy0[PHY_WIDTH-1];
    end
    if (!seen && rx_side) report_timeout("receive online delay");
    if (!seen && !rx_side) report_timeout("transmit strobe");
  endtask

  task automatic drive_random(input int cycles, input bit knock_marker);
    logic [31:0] r0;
    logic [31:0] r1;
    repeat (cycles) begin
      @(posedge clk_wr);
      #0.5;
      r0 = $urandom;
      r1 = $urandom;
      dstrm_data      = r0;
      dstrm_state     = r1[3:0];
      dstrm_protid    = r1[5:4];
      dstrm_dvalid    = r1[6];
      dstrm_crc       = r1[22:7];
      dstrm_crc_valid = r1[23];
      dstrm_valid     = r1[24];
      check_en        = 1'b1;
      force_marker    = knock_marker;
    end
  endtask

  task automatic drive_idle(input int cycles);
    repeat (cycles) begin
      @(posedge clk_wr);
      #0.5;
      {dstrm_state, dstrm_protid, dstrm_data, dstrm_dvalid} = '0;
      {dstrm_crc, dstrm_crc_valid, dstrm_valid} = '0;
      check_en     = 1'b0;
      force_marker = 1'b0;
    end
  endtask

  // Compare process, samples mid cycle
  always @(negedge clk_wr) begin
    int k;
    flit_hist.push_back(pack_dstrm());
    check_hist.push_back(check_en);
    force_hist.push_back(force_marker);
    k = flit_hist.size() - 1;
    if (rst_n && dstrm_valid) valid_count++;
    // Lane 1 upper payload never carries flit bits
    check_value("tx_phy1[37:19]", tx_phy1[LANE_PAYLOAD_WIDTH-1:FLIT_WIDTH-LANE_PAYLOAD_WIDTH], 0);
    // Splitter plus lane register
    if (k >= 2 && check_hist[k-2]) begin
      check_value("tx_phy0", tx_phy0, {2'b11, lane_slice(flit_hist[k-2], 0)});
      check_value("tx_phy1", tx_phy1, {2'b11, lane_slice(flit_hist[k-2], 1)});
    end
    // Four cycle loopback, lane 1 word was on the wire two cycles after entry
    if (k >= 4 && check_hist[k-4]) begin
      check_value("ustrm", pack_ustrm(), ref_upstream(flit_hist[k-4], {~force_hist[k-2], 1'b1}));
    end
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  // Whole test sequence, cut short when an online wait times out
  task automatic run_link_test();
    wait_reset_release();
    if (timed_out) return;

    // Idle and offline, everything quiet
    repeat (8) begin
      @(posedge clk_wr);
      #1;
      check_value("tx_phy0", tx_phy0, 0);
      check_value("tx_phy1", tx_phy1, 0);
      check_value("ustrm_valid", ustrm_valid, 0);
    end

    // Transmit first so the receive side never sees unframed words
    @(posedge clk_wr);
    #0.5;
    tx_online = 1'b1;
    count_edges_until(1'b0, edges);
    if (timed_out) return;
    check_value("tx_phy0 strobe delay", edges, int'(delay_xz_value) + 2);
    @(posedge clk_wr);
    #0.5;
    rx_online = 1'b1;
    count_edges_until(1'b1, edges);
    if (timed_out) return;
    check_value("rx_online_delay delay", edges,
                int'(delay_x_value) + int'(delay_yz_value) + 1);
    drive_idle(4);

    // Random loopback traffic
    drive_random(150, 1'b0);

    // Lane 1 marker knocked out for a burst
    force_cycles = $urandom_range(10, 3);
    align_base = rx_upstream_debug_status;
    drive_random(force_cycles, 1'b1);
    drive_random(20, 1'b0);
    check_value("rx_upstream_debug_status", rx_upstream_debug_status - align_base,
                force_cycles);

    drive_random(100, 1'b0);
    drive_idle(6);
    check_value("tx_downstream_debug_status", tx_downstream_debug_status, valid_count);
  endtask

  initial begin
    void'($urandom(32'h72a0466a));
    {tx_online, rx_online, check_en, force_marker} = '0;
    {dstrm_state, dstrm_protid, dstrm_data, dstrm_dvalid} = '0;
    {dstrm_crc, dstrm_crc_valid, dstrm_valid} = '0;
    delay_x_value  = DELAY_WIDTH'($urandom_range(9, 1));
    delay_xz_value = DELAY_WIDTH'($urandom_range(12, 2));
    delay_yz_value = DELAY_WIDTH'($urandom_range(9, 1));
    {valid_count, value_errors, other_errors} = '0;
    timed_out = 1'b0;
    run_link_test();
    finish_run();
  end

endmodule

/* dv/tb_clock_gen.sv */
/*
 * Testbench clock and reset
 * 4 ns clock, active low reset held for the first 4 cycles
 */

`timescale 1ns/100ps

module tb_clock_gen (
  output logic clk_wr,
  output logic rst_n
);

  initial begin
    clk_wr = 1'b0;
    forever #2 clk_wr = ~clk_wr;
  end

  // Release just after an edge, like the rest of the stimulus
  initial begin
    rst_n = 1'b0;
    repeat (4) @(posedge clk_wr);
    #0.5;
    rst_n = 1'b1;
  end

endmodule

/* src/flit_lane_merger.sv */
/*
 * Flit lane merger
 * Joins the lane payloads back into a flit and drives the upstream
 * LPIF ports, zeroing them and counting errors when a lane is bad
 */

`timescale 1ns/100ps

module flit_lane_merger import lpif_pkg::*; (
  input  logic                            clk_wr,
  input  logic                            rst_n,
  input  logic                            rx_online_delay,
  input  lane_payload_t [LANE_COUNT-1:0]  rx_payload,
  input  logic [LANE_COUNT-1:0]           rx_ok,
  output logic [3:0]                      ustrm_state,
  output logic [1:0]                      ustrm_protid,
  output logic [31:0]                     ustrm_data,
  output logic                            ustrm_dvalid,
  output logic [15:0]                     ustrm_crc,
  output logic                            ustrm_crc_valid,
  output logic                            ustrm_valid,
  output logic [31:0]                     align_error_count
);

  logic [LANE_BUS_WIDTH-1:0] lane_bus;
  lpif_flit_t                rx_flit;
  lpif_flit_t                ustrm_q;
  logic                      all_ok;
  logic                      online_q;

  // Lane 0 in the low bits, upper lane bits beyond the flit dropped
  assign lane_bus = rx_payload;
  assign rx_flit  = lpif_flit_t'(lane_bus[FLIT_WIDTH-1:0]);
  assign all_ok   = &rx_ok;

  ////////////////////////////////////////
  // Upstream flit register
  ////////////////////////////////////////

  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      ustrm_q           <= '0;
      online_q          <= 1'b0;
      align_error_count <= '0;
    end else begin
      ustrm_q  <= all_ok ? rx_flit : '0;
      // Lines up with rx_ok, which lags the online signal by a cycle
      online_q <= rx_online_delay;
      if (online_q && !all_ok) begin
        align_error_count <= align_error_count + 32'd1;
      end
    end
  end

  assign ustrm_state     = ustrm_q.state;
  assign ustrm_protid    = ustrm_q.protid;
  assign ustrm_data      = ustrm_q.data;
  assign ustrm_dvalid    = ustrm_q.dvalid;
  assign ustrm_crc       = ustrm_q.crc;
  assign ustrm_crc_valid = ustrm_q.crc_valid;
  assign ustrm_valid     = ustrm_q.valid;

endmodule

/* src/flit_lane_splitter.sv */
/*
 * Flit lane splitter
 * Packs the downstream LPIF fields into a flit and registers it
 * cut into per-lane payloads, counting flits with valid set
 */

`timescale 1ns/100ps

module flit_lane_splitter import lpif_pkg::*; (
  input  logic                            clk_wr,
  input  logic                            rst_n,
  input  logic [3:0]                      dstrm_state,
  input  logic [1:0]                      dstrm_protid,
  input  logic [31:0]                     dstrm_data,
  input  logic                            dstrm_dvalid,
  input  logic [15:0]                     dstrm_crc,
  input  logic                            dstrm_crc_valid,
  input  logic                            dstrm_valid,
  output lane_payload_t [LANE_COUNT-1:0]  tx_payload,
  output logic [31:0]                     tx_flit_count
);

  lpif_flit_t                flit;
  logic [LANE_BUS_WIDTH-1:0] lane_bus;

  // Field order follows lpif_flit_t
  assign flit.state     = dstrm_state;
  assign flit.protid    = dstrm_protid;
  assign flit.data      = dstrm_data;
  assign flit.dvalid    = dstrm_dvalid;
  assign flit.crc       = dstrm_crc;
  assign flit.crc_valid = dstrm_crc_valid;
  assign flit.valid     = dstrm_valid;

  // Zero extend so the top lane gets zero upper bits
  assign lane_bus = LANE_BUS_WIDTH'(flit);

  ////////////////////////////////////////
  // Lane payload register
  ////////////////////////////////////////

  always_ff @(posedge clk_wr) begin
    tx_payload <= lane_bus;
  end

  // Transmitted flit count, wraps at 32 bits
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      tx_flit_count <= '0;
    end else if (dstrm_valid) begin
      tx_flit_count <= tx_flit_count + 32'd1;
    end
  end

endmodule

/* src/link_online_sync.sv */
/*
 * Online sequencer
 * Delays tx_online and rx_online by programmable counts so the
 * lanes stay quiet until the far side has finished word alignment
 */

`timescale 1ns/100ps

module link_online_sync import lpif_pkg::*; (
  input  logic                   clk_wr,
  input  logic                   rst_n,
  input  logic                   tx_online,
  input  logic                   rx_online,
  input  logic [DELAY_WIDTH-1:0] delay_x_value,
  input  logic [DELAY_WIDTH-1:0] delay_xz_value,
  input  logic [DELAY_WIDTH-1:0] delay_yz_value,
  output logic                   tx_online_delay,
  output logic                   rx_online_delay
);

  ////////////////////////////////////////
  // Channel setup
  ////////////////////////////////////////

  // Index 0 is transmit, index 1 is receive
  logic [1:0]             online_in;
  logic [1:0]             online_q;
  logic [1:0]             online_out;
  logic [DELAY_WIDTH:0]   load_val [2];
  logic [DELAY_WIDTH:0]   cnt      [2];

  assign online_in = {rx_online, tx_online};

  // Transmit waits only for the far side alignment window
  assign load_val[0] = {1'b0, delay_xz_value};

  // Receive waits for word alignment plus the far side window
  // One extra bit keeps the sum from wrapping
  assign load_val[1] = (DELAY_WIDTH+1)'(delay_x_value) + (DELAY_WIDTH+1)'(delay_yz_value);

  ////////////////////////////////////////
  // Down-counters
  ////////////////////////////////////////

  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      online_q   <= '0;
      online_out <= '0;
      for (int i = 0; i < 2; i++) begin
        cnt[i] <= '0;
      end
    end else begin
      online_q <= online_in;
      for (int i = 0; i < 2; i++) begin
        // Load on the first cycle the input is seen high
        if (online_in[i] && !online_q[i]) begin
          cnt[i] <= load_val[i];
        end else if (online_in[i] && (cnt[i] != '0)) begin
          cnt[i] <= cnt[i] - 1'b1;
        end
        // Drops in the cycle after the input falls
        online_out[i] <= online_in[i] && online_q[i] && (cnt[i] == '0);
      end
    end
  end

  assign tx_online_delay = online_out[0];
  assign rx_online_delay = online_out[1];

endmodule

/* src/lpif_link_top.sv */
/*
 * LPIF link layer top
 * Online sequencer, flit splitter, two framed PHY lanes and the
 * receive merger on one clock
 */

`timescale 1ns/100ps

module lpif_link_top import lpif_pkg::*; (
  input  logic                   clk_wr,
  input  logic                   rst_n,
  // Link control
  input  logic                   tx_online,
  input  logic                   rx_online,
  input  logic [DELAY_WIDTH-1:0] delay_x_value,
  input  logic [DELAY_WIDTH-1:0] delay_xz_value,
  input  logic [DELAY_WIDTH-1:0] delay_yz_value,
  // Downstream channel
  input  logic [3:0]             dstrm_state,
  input  logic [1:0]             dstrm_protid,
  input  logic [31:0]            dstrm_data,
  input  logic                   dstrm_dvalid,
  input  logic [15:0]            dstrm_crc,
  input  logic                   dstrm_crc_valid,
  input  logic                   dstrm_valid,
  // Upstream channel
  output logic [3:0]             ustrm_state,
  output logic [1:0]             ustrm_protid,
  output logic [31:0]            ustrm_data,
  output logic                   ustrm_dvalid,
  output logic [15:0]            ustrm_crc,
  output logic                   ustrm_crc_valid,
  output logic                   ustrm_valid,
  // PHY interconnect
  output logic [PHY_WIDTH-1:0]   tx_phy0,
  output logic [PHY_WIDTH-1:0]   tx_phy1,
  input  logic [PHY_WIDTH-1:0]   rx_phy0,
  input  logic [PHY_WIDTH-1:0]   rx_phy1,
  // Debug status
  output logic [31:0]            tx_downstream_debug_status,
  output logic [31:0]            rx_upstream_debug_status
);

  ////////////////////////////////////////
  // Interconnect
  ////////////////////////////////////////

  logic                           tx_online_delay;
  logic                           rx_online_delay;
  lane_payload_t [LANE_COUNT-1:0] tx_payload;
  lane_payload_t [LANE_COUNT-1:0] rx_payload;
  logic [LANE_COUNT-1:0]          rx_ok;
  phy_word_t                      tx_phy [LANE_COUNT];
  phy_word_t                      rx_phy [LANE_COUNT];

  // Lane words to and from the flat PHY ports
  assign tx_phy0   = tx_phy[0];
  assign tx_phy1   = tx_phy[1];
  assign rx_phy[0] = rx_phy0;
  assign rx_phy[1] = rx_phy1;

  link_online_sync u_online_sync (
    .clk_wr          (clk_wr),
    .rst_n           (rst_n),
    .tx_online       (tx_online),
    .rx_online       (rx_online),
    .delay_x_value   (delay_x_value),
    .delay_xz_value  (delay_xz_value),
    .delay_yz_value  (delay_yz_value),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay)
  );

  flit_lane_splitter u_splitter (
    .clk_wr          (clk_wr),
    .rst_n           (rst_n),
    .dstrm_state     (dstrm_state),
    .dstrm_protid    (dstrm_protid),
    .dstrm_data      (dstrm_data),
    .dstrm_dvalid    (dstrm_dvalid),
    .dstrm_crc       (dstrm_crc),
    .dstrm_crc_valid (dstrm_crc_valid),
    .dstrm_valid     (dstrm_valid),
    .tx_payload      (tx_payload),
    .tx_flit_count   (tx_downstream_debug_status)
  );

  ////////////////////////////////////////
  // PHY lanes
  ////////////////////////////////////////

  for (genvar g = 0; g < LANE_COUNT; g++) begin : g_lane
    phy_lane u_lane (
      .clk_wr          (clk_wr),
      .rst_n           (rst_n),
      .tx_online_delay (tx_online_delay),
      .rx_online_delay (rx_online_delay),
      .tx_payload      (tx_payload[g]),
      .tx_phy          (tx_phy[g]),
      .rx_phy          (rx_phy[g]),
      .rx_payload      (rx_payload[g]),
      .rx_ok           (rx_ok[g])
    );
  end

  flit_lane_merger u_merger (
    .clk_wr            (clk_wr),
    .rst_n             (rst_n),
    .rx_online_delay   (rx_online_delay),
    .rx_payload        (rx_payload),
    .rx_ok             (rx_ok),
    .ustrm_state       (ustrm_state),
    .ustrm_protid      (ustrm_protid),
    .ustrm_data        (ustrm_data),
    .ustrm_dvalid      (ustrm_dvalid),
    .ustrm_crc         (ustrm_crc),
    .ustrm_crc_valid   (ustrm_crc_valid),
    .ustrm_valid       (ustrm_valid),
    .align_error_count (rx_upstream_debug_status)
  );

endmodule

/* src/lpif_pkg.sv */
/*
 * LPIF die-to-die link layer definitions
 * Lane geometry, delay widths and the flit and lane word layouts
 * shared by the sequencer, splitter, PHY lanes and merger
 */

package lpif_pkg;

  ////////////////////////////////////////
  // Link geometry
  ////////////////////////////////////////

  // Two PHY lanes carry one flit
  localparam int LANE_COUNT         = 2;

  // Full lane word as seen on the PHY
  localparam int PHY_WIDTH          = 40;

  // Lane word minus strobe and marker
  localparam int LANE_PAYLOAD_WIDTH = 38;

  // Downstream and upstream LPIF fields packed together
  localparam int FLIT_WIDTH         = 57;

  // Online delay counts
  localparam int DELAY_WIDTH        = 8;

  // All lane payloads side by side, lane 0 lowest
  localparam int LANE_BUS_WIDTH     = LANE_COUNT * LANE_PAYLOAD_WIDTH;

  ////////////////////////////////////////
  // Flit and lane word types
  ////////////////////////////////////////

  // One flit, state in the top bits and valid in bit 0
  typedef struct packed {
    logic [3:0]  state;
    logic [1:0]  protid;
    logic [31:0] data;
    logic        dvalid;
    logic [15:0] crc;
    logic        crc_valid;
    logic        valid;
  } lpif_flit_t;

  // Payload slice carried by one lane
  typedef logic [LANE_PAYLOAD_WIDTH-1:0] lane_payload_t;

  // Lane word on the wire
  // Strobe and marker both high on every online word
  typedef struct packed {
    logic          strobe;
    logic          marker;
    lane_payload_t payload;
  } phy_word_t;

  // Lane 0 takes flit bits 37..0
  // Lane 1 takes flit bits 56..38 in its low bits, upper bits zero
  // Both sides rely on a plain zero extended slice of the flit

endpackage

/* src/phy_lane.sv */
/*
 * One PHY lane
 * Transmit side frames the payload with strobe and marker
 * Receive side checks both framing bits before passing the payload on
 */

`timescale 1ns/100ps

module phy_lane import lpif_pkg::*; (
  input  logic          clk_wr,
  input  logic          rst_n,
  input  logic          tx_online_delay,
  input  logic          rx_online_delay,
  input  lane_payload_t tx_payload,
  output phy_word_t     tx_phy,
  input  phy_word_t     rx_phy,
  output lane_payload_t rx_payload,
  output logic          rx_ok
);

  ////////////////////////////////////////
  // Transmit framing
  ////////////////////////////////////////

  phy_word_t tx_word;
  logic      rx_framed;

  // Whole word held at zero until the lane goes online
  always_comb begin
    tx_word = '0;
    if (tx_online_delay) begin
      tx_word.strobe  = 1'b1;
      tx_word.marker  = 1'b1;
      tx_word.payload = tx_payload;
    end
  end

  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      tx_phy <= '0;
    end else begin
      tx_phy <= tx_word;
    end
  end

  ////////////////////////////////////////
  // Receive checking
  ////////////////////////////////////////

  // Strobe and marker must both be present
  assign rx_framed = rx_phy.strobe & rx_phy.marker;

  // Payload follows the wire every cycle
  always_ff @(posedge clk_wr) begin
    rx_payload <= rx_phy.payload;
  end

  // Good word flag
  // Only counts once the receive side is online
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      rx_ok <= 1'b0;
    end else begin
      rx_ok <= rx_online_delay & rx_framed;
    end
  end

endmodule
